// File: design/gpu_cfg_pkg.sv
package gpu_cfg_pkg;

    // Core sizes
    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NW_BITS      = $clog2(NUM_WARPS);
    localparam int NT_BITS      = $clog2(NUM_THREADS);
    localparam int XLEN         = 32;
    localparam int NUM_BARRIERS = 4;
    localparam int NB_BITS      = $clog2(NUM_BARRIERS);

    // One extra pointer bit so a full stack can be counted
    localparam int DV_STACK_SIZE  = 4;
    localparam int DV_STACK_SIZEW = $clog2(DV_STACK_SIZE) + 1;

    // Barrier sizes and arrival counts reach NUM_WARPS
    localparam int BAR_SIZE_W = NW_BITS + 1;

    localparam logic [XLEN-1:0] START_PC = 32'h8000_0000;

endpackage

// File: design/wctl_op_pkg.sv
package wctl_op_pkg;

    // Warp control operation codes
    localparam logic [2:0] OP_TMC    = 3'd0;
    localparam logic [2:0] OP_PRED   = 3'd1;
    localparam logic [2:0] OP_SPLIT  = 3'd2;
    localparam logic [2:0] OP_JOIN   = 3'd3;
    localparam logic [2:0] OP_BAR    = 3'd4;
    localparam logic [2:0] OP_WSPAWN = 3'd5;

    // rs1 of the last active lane, read as barrier id or as a count
    typedef union packed {
        struct packed {
            logic [gpu_cfg_pkg::XLEN-17-gpu_cfg_pkg::NB_BITS:0] rsvd_hi;
            logic [gpu_cfg_pkg::NB_BITS-1:0]                    bar_id;
            logic [15:0]                                        rsvd_lo;
        } bar_view;
        struct packed {
            logic [gpu_cfg_pkg::XLEN-gpu_cfg_pkg::DV_STACK_SIZEW-1:0] rsvd;
            logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0]                   cnt;
        } cnt_view;
    } rs1_ctl_u;

    // Width of the strobe payload held between the two strobe stages
    localparam int CTL_W = gpu_cfg_pkg::NW_BITS + 4 * gpu_cfg_pkg::NUM_THREADS
                         + 2 * gpu_cfg_pkg::XLEN + gpu_cfg_pkg::DV_STACK_SIZEW
                         + gpu_cfg_pkg::NB_BITS + gpu_cfg_pkg::BAR_SIZE_W
                         + gpu_cfg_pkg::NUM_WARPS;

endpackage

// File: design/wctl_unit.sv
module wctl_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    output logic req_ready,
    input  logic [2:0] req_op,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] req_wid,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] req_tmask,
    input  logic req_cond_neg,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0][gpu_cfg_pkg::XLEN-1:0] req_rs1,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0][gpu_cfg_pkg::XLEN-1:0] req_rs2,
    output logic [gpu_cfg_pkg::NB_BITS-1:0] req_bar_id,
    input  logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] stack_ptr,
    input  logic bar_phase,
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::XLEN-1:0] warp_pc,
    output logic tmc_valid,
    output logic split_valid,
    output logic join_valid,
    output logic bar_valid,
    output logic spawn_valid,
    output logic [gpu_cfg_pkg::NW_BITS-1:0] ctl_wid,
    output logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_tmask,
    output logic [gpu_cfg_pkg::XLEN-1:0] ctl_pc_next,
    output logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_taken_mask,
    output logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_other_mask,
    output logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_orig_mask,
    output logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] join_ptr,
    output logic [gpu_cfg_pkg::NB_BITS-1:0] bar_id,
    output logic [gpu_cfg_pkg::BAR_SIZE_W-1:0] bar_size,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0] spawn_mask,
    output logic [gpu_cfg_pkg::XLEN-1:0] spawn_pc,
    output logic rsp_valid,
    input  logic rsp_ready,
    output logic [gpu_cfg_pkg::NW_BITS-1:0] rsp_wid,
    output logic [gpu_cfg_pkg::XLEN-1:0] rsp_data
);
    logic [gpu_cfg_pkg::NT_BITS-1:0] last_lane;
    wctl_op_pkg::rs1_ctl_u rs1_ctl;
    logic [gpu_cfg_pkg::XLEN-1:0] rs2_last, res_word;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] taken, then_mask, else_mask;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] first_mask, second_mask, new_mask;
    logic [gpu_cfg_pkg::NUM_WARPS-1:0] spawn_m;
    int then_cnt, else_cnt;
    logic acc, pop, dvg;
    logic [4:0] s1_vld;
    logic [wctl_op_pkg::CTL_W-1:0] s1_data;
    logic [1:0] settle, buf_cnt;
    logic wr_ptr, rd_ptr;
    logic [gpu_cfg_pkg::NW_BITS-1:0] buf_wid [2];
    logic [gpu_cfg_pkg::XLEN-1:0] buf_data [2];

    // Highest set lane of the request mask and lane counts
    always_comb begin
        last_lane = '0;
        then_cnt = 0;
        else_cnt = 0;
        for (int i = 0; i < gpu_cfg_pkg::NUM_THREADS; i++) begin
            taken[i] = req_rs1[i][0] ^ req_cond_neg;
            if (req_tmask[i])
                last_lane = i[gpu_cfg_pkg::NT_BITS-1:0];
            then_cnt += int'(taken[i] & req_tmask[i]);
            else_cnt += int'(~taken[i] & req_tmask[i]);
        end
    end

    // Spawn targets from the count view
    always_comb begin
        for (int w = 0; w < gpu_cfg_pkg::NUM_WARPS; w++)
            spawn_m[w] = (w < int'(rs1_ctl.cnt_view.cnt)) && (w != int'(req_wid));
    end

    assign rs1_ctl    = req_rs1[last_lane];
    assign rs2_last   = req_rs2[last_lane];
    assign req_bar_id = rs1_ctl.bar_view.bar_id;
    assign then_mask  = taken & req_tmask;
    assign else_mask  = ~taken & req_tmask;
    assign dvg        = (then_mask != '0) && (else_mask != '0);

    // Smaller side runs first, then side wins a tie
    assign first_mask  = (then_cnt <= else_cnt) ? then_mask : else_mask;
    assign second_mask = (then_cnt <= else_cnt) ? else_mask : then_mask;

    always_comb begin
        if (req_op == wctl_op_pkg::OP_PRED)
            new_mask = (then_mask != '0) ? then_mask : rs2_last[gpu_cfg_pkg::NUM_THREADS-1:0];
        else if (req_op == wctl_op_pkg::OP_TMC)
            new_mask = rs1_ctl[gpu_cfg_pkg::NUM_THREADS-1:0];
        else
            new_mask = first_mask;
        res_word = '0;
        if (req_op == wctl_op_pkg::OP_SPLIT || req_op == wctl_op_pkg::OP_JOIN)
            res_word[gpu_cfg_pkg::DV_STACK_SIZEW-1:0] = stack_ptr;
        else if (req_op == wctl_op_pkg::OP_BAR)
            res_word[0] = bar_phase;
    end

    assign acc       = req_valid && req_ready;
    assign pop       = rsp_valid && rsp_ready;
    assign req_ready = (settle == 2'd0) && (buf_cnt != 2'd2);

    // Two strobe stages so the strobes sit between edges N+1 and N+2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= '0;
            {tmc_valid, split_valid, join_valid, bar_valid, spawn_valid} <= '0;
        end else begin
            s1_vld <= acc ? {req_op == wctl_op_pkg::OP_TMC || req_op == wctl_op_pkg::OP_PRED,
                             req_op == wctl_op_pkg::OP_SPLIT && dvg,
                             req_op == wctl_op_pkg::OP_JOIN,
                             req_op == wctl_op_pkg::OP_BAR,
                             req_op == wctl_op_pkg::OP_WSPAWN} : 5'b0;
            {tmc_valid, split_valid, join_valid, bar_valid, spawn_valid} <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (acc)
            s1_data <= {req_wid, new_mask, warp_pc[req_wid] + 4, first_mask, second_mask,
                        req_tmask, rs1_ctl.cnt_view.cnt, rs1_ctl.bar_view.bar_id,
                        rs2_last[gpu_cfg_pkg::BAR_SIZE_W-1:0], spawn_m, rs2_last};
        {ctl_wid, ctl_tmask, ctl_pc_next, ctl_taken_mask, ctl_other_mask, ctl_orig_mask,
         join_ptr, bar_id, bar_size, spawn_mask, spawn_pc} <= s1_data;
    end

    // Settle counter and result buffer pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            settle  <= '0;
            buf_cnt <= '0;
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
        end else begin
            if (acc)
                settle <= 2'd2;
            else if (settle != 2'd0)
                settle <= settle - 2'd1;
            buf_cnt <= buf_cnt + 2'(acc) - 2'(pop);
            if (acc)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            buf_wid[wr_ptr]  <= req_wid;
            buf_data[wr_ptr] <= res_word;
        end
    end

    assign rsp_valid = (buf_cnt != 2'd0);
    assign rsp_wid   = buf_wid[rd_ptr];
    assign rsp_data  = buf_data[rd_ptr];

endmodule

// File: design/ipdom_stack.sv
module ipdom_stack (
    input  logic clk,
    input  logic rst_n,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] req_wid,
    output logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] stack_ptr,
    input  logic split_valid,
    input  logic join_valid,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] ctl_wid,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_taken_mask,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_other_mask,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_orig_mask,
    input  logic [gpu_cfg_pkg::XLEN-1:0] ctl_pc_next,
    input  logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] join_ptr,
    output logic restore_valid,
    output logic [gpu_cfg_pkg::NW_BITS-1:0] restore_wid,
    output logic [gpu_cfg_pkg::NUM_THREADS-1:0] restore_tmask,
    output logic [gpu_cfg_pkg::XLEN-1:0] restore_pc,
    output logic restore_set_pc
);
    logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::DV_STACK_SIZEW-1:0] depth;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] stk_else [gpu_cfg_pkg::NUM_WARPS][gpu_cfg_pkg::DV_STACK_SIZE];
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] stk_orig [gpu_cfg_pkg::NUM_WARPS][gpu_cfg_pkg::DV_STACK_SIZE];
    logic [gpu_cfg_pkg::XLEN-1:0] stk_pc [gpu_cfg_pkg::NUM_WARPS][gpu_cfg_pkg::DV_STACK_SIZE];
    logic stk_done [gpu_cfg_pkg::NUM_WARPS][gpu_cfg_pkg::DV_STACK_SIZE];
    logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] cur_depth, top;
    logic push, join_act;

    assign stack_ptr = depth[req_wid];
    assign cur_depth = depth[ctl_wid];
    assign top       = cur_depth - 1;

    // Depth is a power of two, so the top pointer bit means full
    assign push     = split_valid && (ctl_taken_mask != '0) && (ctl_other_mask != '0)
                   && !cur_depth[gpu_cfg_pkg::DV_STACK_SIZEW-1];
    assign join_act = join_valid && (cur_depth > join_ptr);

    // Else side pending: switch to it, else pop back to the original mask
    assign restore_valid  = join_act;
    assign restore_wid    = ctl_wid;
    assign restore_set_pc = !stk_done[ctl_wid][top[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]];
    assign restore_pc     = stk_pc[ctl_wid][top[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]];
    assign restore_tmask  = restore_set_pc ? stk_else[ctl_wid][top[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]]
                                           : stk_orig[ctl_wid][top[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            depth <= '0;
        else if (push)
            depth[ctl_wid] <= cur_depth + 1;
        else if (join_act && !restore_set_pc)
            depth[ctl_wid] <= top;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stk_else[ctl_wid][cur_depth[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]] <= ctl_other_mask;
            stk_orig[ctl_wid][cur_depth[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]] <= ctl_orig_mask;
            stk_pc[ctl_wid][cur_depth[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]]   <= ctl_pc_next;
            stk_done[ctl_wid][cur_depth[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]] <= 1'b0;
        end else if (join_act && restore_set_pc) begin
            stk_done[ctl_wid][top[gpu_cfg_pkg::DV_STACK_SIZEW-2:0]] <= 1'b1;
        end
    end

endmodule

// File: design/barrier_counter.sv
module barrier_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic [gpu_cfg_pkg::NB_BITS-1:0] req_bar_id,
    output logic bar_phase,
    input  logic bar_valid,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] ctl_wid,
    input  logic [gpu_cfg_pkg::NB_BITS-1:0] bar_id,
    input  logic [gpu_cfg_pkg::BAR_SIZE_W-1:0] bar_size,
    output logic arrive_stall,
    output logic release_valid,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0] release_mask
);
    logic [gpu_cfg_pkg::NUM_BARRIERS-1:0][gpu_cfg_pkg::BAR_SIZE_W-1:0] count;
    logic [gpu_cfg_pkg::NUM_BARRIERS-1:0][gpu_cfg_pkg::NUM_WARPS-1:0] waiting;
    logic [gpu_cfg_pkg::NUM_BARRIERS-1:0] phase;
    logic [gpu_cfg_pkg::BAR_SIZE_W-1:0] next_count;
    logic complete;

    assign bar_phase  = phase[req_bar_id];
    assign next_count = count[bar_id] + 1;
    assign complete   = (next_count >= bar_size);

    // Last arrival releases the others and does not stall itself
    assign release_valid = bar_valid && complete;
    assign release_mask  = waiting[bar_id];
    assign arrive_stall  = bar_valid && !complete;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            waiting <= '0;
            phase   <= '0;
        end else if (bar_valid) begin
            if (complete) begin
                count[bar_id]   <= '0;
                waiting[bar_id] <= '0;
                phase[bar_id]   <= ~phase[bar_id];
            end else begin
                count[bar_id]            <= next_count;
                waiting[bar_id][ctl_wid] <= 1'b1;
            end
        end
    end

endmodule

// File: design/warp_sched.sv
module warp_sched (
    input  logic clk,
    input  logic rst_n,
    input  logic tmc_valid,
    input  logic split_valid,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] ctl_wid,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_tmask,
    input  logic spawn_valid,
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0] spawn_mask,
    input  logic [gpu_cfg_pkg::XLEN-1:0] spawn_pc,
    input  logic restore_valid,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] restore_wid,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] restore_tmask,
    input  logic [gpu_cfg_pkg::XLEN-1:0] restore_pc,
    input  logic restore_set_pc,
    input  logic arrive_stall,
    input  logic release_valid,
    input  logic [gpu_cfg_pkg::NUM_WARPS-1:0] release_mask,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0] warp_active,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0] warp_stalled,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::NUM_THREADS-1:0] warp_tmask,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::XLEN-1:0] warp_pc
);
    // Per warp {active, stalled}: 00 idle, 10 running, 11 barrier wait
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            warp_active      <= '0;
            warp_active[0]   <= 1'b1;
            warp_stalled     <= '0;
            warp_tmask       <= '0;
            warp_tmask[0][0] <= 1'b1;
            warp_pc          <= '0;
            warp_pc[0]       <= gpu_cfg_pkg::START_PC;
        end else begin
            for (int w = 0; w < gpu_cfg_pkg::NUM_WARPS; w++) begin
                if (spawn_valid && spawn_mask[w]) begin
                    warp_active[w]   <= 1'b1;
                    warp_stalled[w]  <= 1'b0;
                    warp_tmask[w]    <= '0;
                    warp_tmask[w][0] <= 1'b1;
                    warp_pc[w]       <= spawn_pc;
                end else if (tmc_valid && int'(ctl_wid) == w) begin
                    // Zero mask sends the warp back to idle
                    warp_tmask[w]  <= ctl_tmask;
                    warp_active[w] <= (ctl_tmask != '0);
                    if (ctl_tmask == '0)
                        warp_stalled[w] <= 1'b0;
                end else if (split_valid && int'(ctl_wid) == w) begin
                    warp_tmask[w] <= ctl_tmask;
                end else if (restore_valid && int'(restore_wid) == w) begin
                    warp_tmask[w] <= restore_tmask;
                    if (restore_set_pc)
                        warp_pc[w] <= restore_pc;
                end else if (arrive_stall && int'(ctl_wid) == w) begin
                    warp_stalled[w] <= 1'b1;
                end else if (release_valid && release_mask[w]) begin
                    warp_stalled[w] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/warp_ctl_top.sv
module warp_ctl_top (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    output logic req_ready,
    input  logic [2:0] req_op,
    input  logic [gpu_cfg_pkg::NW_BITS-1:0] req_wid,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0] req_tmask,
    input  logic req_cond_neg,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0][gpu_cfg_pkg::XLEN-1:0] req_rs1,
    input  logic [gpu_cfg_pkg::NUM_THREADS-1:0][gpu_cfg_pkg::XLEN-1:0] req_rs2,
    output logic rsp_valid,
    input  logic rsp_ready,
    output logic [gpu_cfg_pkg::NW_BITS-1:0] rsp_wid,
    output logic [gpu_cfg_pkg::XLEN-1:0] rsp_data,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0] warp_active,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0] warp_stalled,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::NUM_THREADS-1:0] warp_tmask,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::XLEN-1:0] warp_pc
);
    // Lookups back into the control unit
    logic [gpu_cfg_pkg::NB_BITS-1:0] req_bar_id;
    logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] stack_ptr;
    logic bar_phase;

    // Strobes and their payload
    logic tmc_valid, split_valid, join_valid, bar_valid, spawn_valid;
    logic [gpu_cfg_pkg::NW_BITS-1:0] ctl_wid;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] ctl_tmask, ctl_taken_mask, ctl_other_mask, ctl_orig_mask;
    logic [gpu_cfg_pkg::XLEN-1:0] ctl_pc_next, spawn_pc;
    logic [gpu_cfg_pkg::DV_STACK_SIZEW-1:0] join_ptr;
    logic [gpu_cfg_pkg::NB_BITS-1:0] bar_id;
    logic [gpu_cfg_pkg::BAR_SIZE_W-1:0] bar_size;
    logic [gpu_cfg_pkg::NUM_WARPS-1:0] spawn_mask;

    // Stack and barrier commands to the scheduler
    logic restore_valid, restore_set_pc;
    logic [gpu_cfg_pkg::NW_BITS-1:0] restore_wid;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] restore_tmask;
    logic [gpu_cfg_pkg::XLEN-1:0] restore_pc;
    logic arrive_stall, release_valid;
    logic [gpu_cfg_pkg::NUM_WARPS-1:0] release_mask;

    wctl_unit u_wctl_unit (.*);

    ipdom_stack u_ipdom_stack (.*);

    barrier_counter u_barrier_counter (.*);

    warp_sched u_warp_sched (.*);

endmodule

// File: bench/warp_ctl_asserts.sv
module warp_ctl_asserts (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_ready,
    input logic rsp_valid,
    input logic rsp_ready,
    input logic [31:0] rsp_data,
    input logic [3:0] warp_active,
    input logic [3:0] warp_stalled
);
    // Two settle cycles after every accept
    ready_settle: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready) |=> !req_ready ##1 !req_ready)
        else $error("req_ready high within two cycles of an accept");

    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> $stable(rsp_data))
        else $error("rsp_data changed under back-pressure");

    stall_active: assert property (@(posedge clk) disable iff (!rst_n)
        (warp_stalled & ~warp_active) == 4'h0)
        else $error("stalled warp is not active");

endmodule

bind wctl_unit warp_ctl_asserts u_unit_asserts (.clk, .rst_n, .req_valid, .req_ready,
    .rsp_valid, .rsp_ready, .rsp_data, .warp_active(4'hF), .warp_stalled(4'h0));

bind warp_sched warp_ctl_asserts u_sched_asserts (.clk, .rst_n, .req_valid(1'b0),
    .req_ready(1'b1), .rsp_valid(1'b0), .rsp_ready(1'b1), .rsp_data(32'h0),
    .warp_active, .warp_stalled);

// File: bench/tb_warp_ctl.sv
module tb_warp_ctl;

    logic clk, rst_n, req_valid, req_ready, req_cond_neg, rsp_valid, rsp_ready;
    logic [2:0] req_op;
    logic [gpu_cfg_pkg::NW_BITS-1:0] req_wid, rsp_wid;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0] req_tmask;
    logic [gpu_cfg_pkg::NUM_THREADS-1:0][gpu_cfg_pkg::XLEN-1:0] req_rs1, req_rs2;
    logic [gpu_cfg_pkg::XLEN-1:0] rsp_data;
    logic [gpu_cfg_pkg::NUM_WARPS-1:0] warp_active, warp_stalled;
    logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::NUM_THREADS-1:0] warp_tmask;
    logic [gpu_cfg_pkg::NUM_WARPS-1:0][gpu_cfg_pkg::XLEN-1:0] warp_pc;

    // Reference model of warps, divergence stacks and barriers
    logic [gpu_cfg_pkg::NUM_WARPS-1:0] m_active, m_stalled;
    logic [3:0] m_tmask [4];
    logic [31:0] m_pc [4];
    int m_depth [4];
    logic [3:0] s_else [4][4];
    logic [3:0] s_orig [4][4];
    logic [31:0] s_pc [4][4];
    logic s_done [4][4];
    logic [2:0] b_count [4];
    logic b_phase [4];
    logic [3:0] b_wait [4];

    logic [15:0] lfsr, rdy_lfsr;
    logic [33:0] exp_q [$];
    logic drain;
    int errors, checks, e0;
    logic [1:0] wid;

    warp_ctl_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic model_reset();
        m_active = 4'b0001;
        m_stalled = '0;
        for (int w = 0; w < 4; w++) begin
            m_tmask[w] = (w == 0) ? 4'b0001 : 4'b0000;
            m_pc[w] = (w == 0) ? gpu_cfg_pkg::START_PC : 32'h0;
            m_depth[w] = 0;
            b_count[w] = '0;
            b_phase[w] = 1'b0;
            b_wait[w] = '0;
        end
    endtask

    function automatic int ready_warps();
        return $countones(m_active & ~m_stalled);
    endfunction

    task automatic pick_warp(output logic [1:0] w);
        logic [1:0] start;
        start = 2'(rand_bits(2));
        for (int i = 0; i < 4; i++) begin
            w = start + 2'(i);
            if (m_active[w] && !m_stalled[w])
                return;
        end
        $display("No warp is left that can take a request");
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_state();
        for (int w = 0; w < 4; w++) begin
            compare($sformatf("warp %0d active", w), 64'(warp_active[w]), 64'(m_active[w]));
            compare($sformatf("warp %0d stalled", w), 64'(warp_stalled[w]), 64'(m_stalled[w]));
            compare($sformatf("warp %0d tmask", w), 64'(warp_tmask[w]), 64'(m_tmask[w]));
            compare($sformatf("warp %0d pc", w), 64'(warp_pc[w]), 64'(m_pc[w]));
        end
    endtask

    task automatic run_op(input logic [2:0] op, input logic [1:0] w, input int hint);
        logic [3:0] tmask, taken, then_m, else_m, first_m, second_m, nm;
        logic [3:0][31:0] rs1, rs2;
        logic [31:0] res;
        logic [2:0] size;
        logic [1:0] b;
        logic neg;
        int last, n_elig, top, t;
        tmask = m_tmask[w];
        neg = rand_bits(1) != 0;
        last = 0;
        n_elig = ready_warps();
        for (int i = 0; i < 4; i++) begin
            rs1[i] = rand_bits(32);
            rs2[i] = rand_bits(32);
            if (tmask[i])
                last = i;
        end
        if (op == wctl_op_pkg::OP_TMC && hint >= 0)
            rs1[last][3:0] = 4'(hint);
        // Keep at least one warp able to issue
        if (op == wctl_op_pkg::OP_TMC && rs1[last][3:0] == 4'h0 && n_elig < 2)
            rs1[last][0] = 1'b1;
        if (op == wctl_op_pkg::OP_JOIN || op == wctl_op_pkg::OP_WSPAWN)
            rs1[last][2:0] = (hint >= 0) ? 3'(hint) : 3'(rand_bits(2));
        b = rs1[last][17:16];
        size = 3'(rand_bits(2)) + 3'd1;
        if (b_count[b] + 3'd1 < size && n_elig < 2)
            size = b_count[b] + 3'd1;
        if (op == wctl_op_pkg::OP_BAR)
            rs2[last][2:0] = size;
        for (int i = 0; i < 4; i++)
            taken[i] = rs1[i][0] ^ neg;
        then_m = taken & tmask;
        else_m = ~taken & tmask;
        if (op == wctl_op_pkg::OP_PRED && then_m == 4'h0 && rs2[last][3:0] == 4'h0 && n_elig < 2)
            rs2[last][0] = 1'b1;
        first_m = ($countones(then_m) <= $countones(else_m)) ? then_m : else_m;
        second_m = ($countones(then_m) <= $countones(else_m)) ? else_m : then_m;
        res = '0;
        case (op)
            wctl_op_pkg::OP_TMC, wctl_op_pkg::OP_PRED: begin
                if (op == wctl_op_pkg::OP_TMC)
                    nm = rs1[last][3:0];
                else
                    nm = (then_m != 4'h0) ? then_m : rs2[last][3:0];
                m_tmask[w] = nm;
                m_active[w] = nm != 4'h0;
            end
            wctl_op_pkg::OP_SPLIT: begin
                res = 32'(m_depth[w]);
                if (then_m != 4'h0 && else_m != 4'h0) begin
                    if (m_depth[w] < 4) begin
                        s_else[w][m_depth[w]] = second_m;
                        s_orig[w][m_depth[w]] = tmask;
                        s_pc[w][m_depth[w]] = m_pc[w] + 32'd4;
                        s_done[w][m_depth[w]] = 1'b0;
                        m_depth[w]++;
                    end
                    m_tmask[w] = first_m;
                end
            end
            wctl_op_pkg::OP_JOIN: begin
                res = 32'(m_depth[w]);
                top = m_depth[w] - 1;
                if (m_depth[w] > int'(rs1[last][2:0])) begin
                    if (!s_done[w][top]) begin
                        m_tmask[w] = s_else[w][top];
                        m_pc[w] = s_pc[w][top];
                        s_done[w][top] = 1'b1;
                    end else begin
                        m_tmask[w] = s_orig[w][top];
                        m_depth[w]--;
                    end
                end
            end
            wctl_op_pkg::OP_BAR: begin
                res = 32'(b_phase[b]);
                if (b_count[b] + 3'd1 >= size) begin
                    m_stalled = m_stalled & ~b_wait[b];
                    b_count[b] = '0;
                    b_wait[b] = '0;
                    b_phase[b] = ~b_phase[b];
                end else begin
                    b_count[b]++;
                    b_wait[b][w] = 1'b1;
                    m_stalled[w] = 1'b1;
                end
            end
            default: begin
                for (int v = 0; v < 4; v++) begin
                    if (v < int'(rs1[last][2:0]) && v != int'(w)) begin
                        m_active[v] = 1'b1;
                        m_stalled[v] = 1'b0;
                        m_tmask[v] = 4'b0001;
                        m_pc[v] = rs2[last];
                    end
                end
            end
        endcase
        exp_q.push_back({w, res});
        @(posedge clk);
        req_valid <= 1'b1;
        req_op <= op;
        req_wid <= w;
        req_tmask <= tmask;
        req_cond_neg <= neg;
        req_rs1 <= rs1;
        req_rs2 <= rs2;
        t = 0;
        @(negedge clk);
        while (!req_ready) begin
            t++;
            if (t > 200)
                timed_out("req_ready");
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_state();
    endtask

    task automatic report(input string name);
        $display("Test %s: %0d errors", name, errors - e0);
        e0 = errors;
    endtask

    // Random back-pressure on the result port
    initial begin
        rdy_lfsr = 16'd52953;
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            rdy_lfsr = lfsr_next(rdy_lfsr);
            rsp_ready <= drain | rdy_lfsr[0];
        end
    end

    // Results leave on the next rising edge when valid and ready are high here
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("A result came out with none outstanding");
                end else begin
                    compare("result wid and data", 64'({rsp_wid, rsp_data}),
                            64'(exp_q.pop_front()));
                end
            end
        end
    end

    initial begin
        int t;
        lfsr = 16'd52953;
        errors = 0;
        checks = 0;
        e0 = 0;
        drain = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_op = '0;
        req_wid = '0;
        req_tmask = '0;
        req_cond_neg = 1'b0;
        req_rs1 = '0;
        req_rs2 = '0;
        model_reset();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check_state();
        run_op(wctl_op_pkg::OP_WSPAWN, 2'd0, 4);
        report("reset and spawn");

        pick_warp(wid);
        run_op(wctl_op_pkg::OP_TMC, wid, 0);
        repeat (20) begin
            pick_warp(wid);
            run_op(rand_bits(1) != 0 ? wctl_op_pkg::OP_TMC : wctl_op_pkg::OP_PRED, wid, -1);
        end
        report("tmc and pred");

        pick_warp(wid);
        run_op(wctl_op_pkg::OP_WSPAWN, wid, 4);
        repeat (30) begin
            pick_warp(wid);
            run_op(rand_bits(2) != 0 ? wctl_op_pkg::OP_SPLIT : wctl_op_pkg::OP_JOIN, wid, -1);
        end
        report("split and join");

        repeat (20) begin
            pick_warp(wid);
            run_op(wctl_op_pkg::OP_BAR, wid, -1);
        end
        report("barriers");

        repeat (60) begin
            pick_warp(wid);
            run_op(3'(rand_bits(3) % 6), wid, -1);
        end
        drain = 1'b1;
        t = 0;
        while (exp_q.size() != 0) begin
            t++;
            if (t > 50)
                timed_out("the remaining results");
            @(negedge clk);
        end
        report("mixed with back-pressure");

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: sim.f
design/gpu_cfg_pkg.sv
design/wctl_op_pkg.sv
design/wctl_unit.sv
design/ipdom_stack.sv
design/barrier_counter.sv
design/warp_sched.sv
design/warp_ctl_top.sv
bench/warp_ctl_asserts.sv
bench/tb_warp_ctl.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_warp_ctl -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
